/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := correlator_block_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) $(RUN_FLAGS))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
hw/corr_types_pkg.sv
hw/corr_bus_pkg.sv
hw/corr_control.sv
hw/corr_lane.sv
hw/corr_readback.sv
hw/correlator_block.sv
verif/correlator_block_properties.sv
verif/correlator_block_tb.sv

/* hw/corr_bus_pkg.sv */
package corr_bus_pkg;

   // ------------------------------
   // Word address layout, LSB first
   // ------------------------------
   localparam int ADR_COMP_OFS = 0;                 // 0 real, 1 imaginary
   localparam int ADR_COMP_W   = 1;
   localparam int ADR_SLOT_OFS = ADR_COMP_OFS + ADR_COMP_W;
   localparam int ADR_SLOT_W   = corr_types_pkg::SLOT_W;
   localparam int ADR_LANE_OFS = ADR_SLOT_OFS + ADR_SLOT_W;
   localparam int ADR_LANE_W   = corr_types_pkg::LANE_W;
   localparam int ADR_W        = ADR_LANE_OFS + ADR_LANE_W;

   // ------------------------------
   // Bus types
   // ------------------------------
   typedef logic [ADR_W-1:0]                     wb_adr_t;
   typedef logic [corr_types_pkg::ACCUM_DEF-1:0] wb_data_t;  // One component

endpackage

/* hw/corr_control.sv */
`timescale 1ns/1ps

module corr_control
   import corr_types_pkg::*;
#(
   parameter int IBITS  = IBITS_DEF,
   parameter int TRATE  = TRATE_DEF,
   parameter int NLANES = NLANES_DEF,
   parameter logic [NLANES*TRATE*2*ANT_W-1:0] PAIRS = '0    // {a, b} per lane and slot
) (
   input  logic              clk_x,
   input  logic              reset_i,
   input  logic              en_i,       // Sample offered
   input  sample_t           re_i,
   input  sample_t           im_i,
   input  logic              sw_i,       // Bank switch request
   output logic              ready_o,
   output logic              lane_en_o,  // Slot valid for the lanes
   output slot_t             slot_o,
   output logic              bank_o,     // Active bank
   output logic              swap_o,     // Bank change pulse
   output logic [NLANES-1:0] ra_o,
   output logic [NLANES-1:0] ia_o,
   output logic [NLANES-1:0] rb_o,
   output logic [NLANES-1:0] ib_o
);

   ctrl_state_t      state_q, state_d;
   slot_t            slot_q;
   logic [IBITS-1:0] re_q, im_q;         // Latched sample
   logic             sw_pend_q;
   logic             accept;
   logic             last_slot;

   assign ready_o   = (state_q == ST_IDLE) && !sw_pend_q;  // Held off by a pending switch
   assign accept    = en_i && ready_o;
   assign last_slot = (slot_q == slot_t'(TRATE - 1));
   assign lane_en_o = (state_q == ST_RUN);
   assign slot_o    = slot_q;
   assign swap_o    = (state_q == ST_DRAIN);

   // ------------------------------
   // Control FSM
   // ------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept)
               state_d = ST_RUN;
            else if (sw_pend_q || sw_i)
               state_d = ST_DRAIN;                // Swap with nothing in flight
         end
         ST_RUN: begin
            if (last_slot)
               state_d = (sw_pend_q || sw_i) ? ST_DRAIN : ST_IDLE;
         end
         ST_DRAIN: state_d = ST_IDLE;             // Single cycle
         default:  state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_x) begin
      if (reset_i) begin
         state_q   <= ST_IDLE;
         slot_q    <= '0;
         sw_pend_q <= 1'b0;
         bank_o    <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_RUN)
            slot_q <= last_slot ? '0 : slot_q + 1'b1;  // TRATE slots per sample
         sw_pend_q <= (sw_i || sw_pend_q) && (state_q != ST_DRAIN);  // Merged into a swap
         if (state_q == ST_DRAIN)
            bank_o <= !bank_o;                     // Last write of old bank lands here too
      end
   end

   // Sample register
   always_ff @(posedge clk_x) begin
      if (accept) begin
         re_q <= re_i;
         im_q <= im_i;
      end
   end

   // ------------------------------
   // Pair lookup per lane
   // ------------------------------
   for (genvar l = 0; l < NLANES; l++) begin : g_sel
      logic [2*ANT_W-1:0] pair;
      ant_idx_t           ant_a, ant_b;

      assign pair  = PAIRS[(l*TRATE + int'(slot_q))*2*ANT_W +: 2*ANT_W];
      assign ant_a = pair[2*ANT_W-1:ANT_W];       // Upper half
      assign ant_b = pair[ANT_W-1:0];             // Conjugated one
      assign ra_o[l] = re_q[ant_a];
      assign ia_o[l] = im_q[ant_a];
      assign rb_o[l] = re_q[ant_b];
      assign ib_o[l] = im_q[ant_b];
   end

endmodule

/* hw/corr_lane.sv */
`timescale 1ns/1ps

module corr_lane
   import corr_types_pkg::*;
#(
   parameter int ACCUM = ACCUM_DEF,
   parameter int TRATE = TRATE_DEF
) (
   input  logic  clk_x,
   input  logic  reset_i,
   input  logic  en_i,        // Slot valid
   input  slot_t slot_i,
   input  logic  bank_i,      // Active bank
   input  logic  swap_i,      // Clear flags of new bank
   input  logic  ra_i,
   input  logic  ia_i,
   input  logic  rb_i,
   input  logic  ib_i,
   input  logic  rd_bank_i,   // Read-back port
   input  slot_t rd_slot_i,
   input  logic  rd_comp_i,
   output acc_t  rd_dat_o,
   output logic  rd_valid_o
);

   logic signed [ACCUM-1:0] mem_re [2][TRATE];   // Two banks of visibilities
   logic signed [ACCUM-1:0] mem_im [2][TRATE];
   logic [TRATE-1:0]        valid_q [2];         // Entry touched since swap

   prod_t                   p_re, p_im;
   logic                    s_rr, s_ii, s_ir, s_ri;
   logic signed [ACCUM-1:0] base_re, base_im;

   logic                    wr_en_q;
   logic                    wr_bank_q;
   slot_t                   wr_slot_q;
   logic signed [ACCUM-1:0] sum_re_q, sum_im_q;

   // ------------------------------
   // One-bit complex product a * conj(b)
   // ------------------------------
   assign s_rr = ra_i ^ rb_i;                    // Sign of ra*rb
   assign s_ii = ia_i ^ ib_i;                    // Sign of ia*ib
   assign s_ir = ia_i ^ rb_i;                    // Sign of ia*rb
   assign s_ri = ra_i ^ ib_i;                    // Sign of ra*ib

   // Re = ra*rb + ia*ib
   assign p_re = (s_rr != s_ii) ? prod_t'(0) :
                 (s_rr ? prod_t'(-2) : prod_t'(2));
   // Im = ia*rb - ra*ib
   assign p_im = (s_ir == s_ri) ? prod_t'(0) :
                 (s_ir ? prod_t'(-2) : prod_t'(2));

   // First access after a swap starts from zero
   assign base_re = valid_q[bank_i][slot_i] ? mem_re[bank_i][slot_i] : '0;
   assign base_im = valid_q[bank_i][slot_i] ? mem_im[bank_i][slot_i] : '0;

   // ------------------------------
   // Read stage
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (reset_i)
         wr_en_q <= 1'b0;
      else
         wr_en_q <= en_i;
   end

   always_ff @(posedge clk_x) begin
      wr_bank_q <= bank_i;                        // Bank travels with the sum
      wr_slot_q <= slot_i;
      sum_re_q  <= base_re + p_re;                // Sign extended, wraps
      sum_im_q  <= base_im + p_im;
   end

   // ------------------------------
   // Write stage
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (wr_en_q) begin
         mem_re[wr_bank_q][wr_slot_q] <= sum_re_q;
         mem_im[wr_bank_q][wr_slot_q] <= sum_im_q;
      end
   end

   always_ff @(posedge clk_x) begin
      if (reset_i) begin
         valid_q[0] <= '0;
         valid_q[1] <= '0;
      end else begin
         if (swap_i)
            valid_q[!bank_i] <= '0;               // Bank about to go active
         if (wr_en_q)
            valid_q[wr_bank_q][wr_slot_q] <= 1'b1;
      end
   end

   // Second read port for the host
   assign rd_valid_o = valid_q[rd_bank_i][rd_slot_i];
   assign rd_dat_o   = rd_comp_i ? mem_im[rd_bank_i][rd_slot_i] :
                                   mem_re[rd_bank_i][rd_slot_i];

endmodule

/* hw/corr_readback.sv */
`timescale 1ns/1ps

module corr_readback
   import corr_types_pkg::*;
   import corr_bus_pkg::*;
#(
   parameter int NLANES = NLANES_DEF
) (
   input  logic                clk_x,
   input  logic                reset_i,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  wb_adr_t             wb_adr_i,
   output wb_data_t            wb_dat_o,
   output logic                wb_ack_o,
   input  logic                bank_i,      // Active bank
   output logic                rd_bank_o,   // Inactive bank
   output slot_t               rd_slot_o,
   output logic                rd_comp_o,
   input  acc_t [NLANES-1:0]   rd_dat_i,
   input  logic [NLANES-1:0]   rd_valid_i
);

   logic                  req;
   logic                  start;             // New request seen
   logic [ADR_LANE_W-1:0] sel_lane;
   acc_t                  sel_dat;
   logic                  sel_valid;

   assign req   = wb_cyc_i && wb_stb_i;
   assign start = req && !wb_ack_o;           // No second ack straight after one

   // ------------------------------
   // Address decode
   // ------------------------------
   assign rd_comp_o = wb_adr_i[ADR_COMP_OFS];
   assign rd_slot_o = wb_adr_i[ADR_SLOT_OFS +: ADR_SLOT_W];
   assign sel_lane  = wb_adr_i[ADR_LANE_OFS +: ADR_LANE_W];
   assign rd_bank_o = !bank_i;                // Never the bank being updated

   // Lane mux, unused lane numbers read as empty
   assign sel_valid = (int'(sel_lane) < NLANES) && rd_valid_i[sel_lane];
   assign sel_dat   = rd_dat_i[sel_lane];

   // ------------------------------
   // Ack and data
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (reset_i)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= start;                    // One cycle latency
   end

   always_ff @(posedge clk_x) begin
      if (start)
         wb_dat_o <= (wb_we_i || !sel_valid) ? '0 : wb_data_t'(sel_dat);  // Writes ignored
   end

endmodule

/* hw/corr_types_pkg.sv */
package corr_types_pkg;

   // ------------------------------
   // Default sizes
   // ------------------------------
   localparam int IBITS_DEF  = 8;                   // Antennas
   localparam int ACCUM_DEF  = 16;                  // Bits per component
   localparam int TRATE_DEF  = 4;                   // Slots per sample
   localparam int NLANES_DEF = 4;                   // Parallel lanes

   localparam int ANT_W  = $clog2(IBITS_DEF);       // Antenna index bits
   localparam int SLOT_W = $clog2(TRATE_DEF);       // Slot index bits
   localparam int LANE_W = $clog2(NLANES_DEF);      // Lane index bits

   // ------------------------------
   // Types
   // ------------------------------
   typedef logic [IBITS_DEF-1:0]        sample_t;   // One sign bit per antenna
   typedef logic [ANT_W-1:0]            ant_idx_t;
   typedef logic [SLOT_W-1:0]           slot_t;
   typedef logic signed [ACCUM_DEF-1:0] acc_t;      // Wraps on overflow
   typedef logic signed [2:0]           prod_t;     // Only -2, 0 or +2

   typedef enum logic [1:0] {
      ST_IDLE,                                      // Waiting for a sample
      ST_RUN,                                       // Stepping through slots
      ST_DRAIN                                      // Pipeline empty, bank swap
   } ctrl_state_t;

endpackage

/* hw/correlator_block.sv */
`timescale 1ns/1ps

module correlator_block
   import corr_types_pkg::*;
   import corr_bus_pkg::*;
#(
   parameter int IBITS  = IBITS_DEF,
   parameter int ACCUM  = ACCUM_DEF,
   parameter int TRATE  = TRATE_DEF,
   parameter int NLANES = NLANES_DEF,
   // Entry (lane*TRATE + slot) holds {a, b}, entry 0 in the low bits
   parameter logic [NLANES*TRATE*2*ANT_W-1:0] PAIRS = {
      3'd2, 3'd5,  3'd2, 3'd4,  3'd2, 3'd3,  3'd1, 3'd7,   // Lane 3
      3'd1, 3'd6,  3'd1, 3'd5,  3'd1, 3'd4,  3'd1, 3'd3,   // Lane 2
      3'd1, 3'd2,  3'd0, 3'd7,  3'd0, 3'd6,  3'd0, 3'd5,   // Lane 1
      3'd0, 3'd4,  3'd0, 3'd3,  3'd0, 3'd2,  3'd0, 3'd1    // Lane 0
   }
) (
   input  logic     clk_x,
   input  logic     reset_i,
   input  logic     en_i,
   input  sample_t  re_i,
   input  sample_t  im_i,
   input  logic     sw_i,
   output logic     ready_o,
   output logic     bank_o,
   input  logic     wb_cyc_i,
   input  logic     wb_stb_i,
   input  logic     wb_we_i,
   input  wb_adr_t  wb_adr_i,
   output wb_data_t wb_dat_o,
   output logic     wb_ack_o
);

   logic              lane_en;
   slot_t             slot;
   logic              swap;
   logic [NLANES-1:0] ra, ia, rb, ib;         // Selected sign bits per lane
   logic              rd_bank;
   slot_t             rd_slot;
   logic              rd_comp;
   acc_t [NLANES-1:0] rd_dat;
   logic [NLANES-1:0] rd_valid;

   // ------------------------------
   // Controller
   // ------------------------------
   corr_control #(
      .IBITS (IBITS),
      .TRATE (TRATE),
      .NLANES(NLANES),
      .PAIRS (PAIRS)
   ) u_control (
      .clk_x    (clk_x),
      .reset_i  (reset_i),
      .en_i     (en_i),
      .re_i     (re_i),
      .im_i     (im_i),
      .sw_i     (sw_i),
      .ready_o  (ready_o),
      .lane_en_o(lane_en),
      .slot_o   (slot),
      .bank_o   (bank_o),
      .swap_o   (swap),
      .ra_o     (ra),
      .ia_o     (ia),
      .rb_o     (rb),
      .ib_o     (ib)
   );

   // ------------------------------
   // Correlator lanes
   // ------------------------------
   for (genvar l = 0; l < NLANES; l++) begin : g_lane
      corr_lane #(
         .ACCUM(ACCUM),
         .TRATE(TRATE)
      ) u_lane (
         .clk_x     (clk_x),
         .reset_i   (reset_i),
         .en_i      (lane_en),
         .slot_i    (slot),
         .bank_i    (bank_o),
         .swap_i    (swap),
         .ra_i      (ra[l]),
         .ia_i      (ia[l]),
         .rb_i      (rb[l]),
         .ib_i      (ib[l]),
         .rd_bank_i (rd_bank),
         .rd_slot_i (rd_slot),
         .rd_comp_i (rd_comp),
         .rd_dat_o  (rd_dat[l]),
         .rd_valid_o(rd_valid[l])
      );
   end

   // ------------------------------
   // Host read-back
   // ------------------------------
   corr_readback #(
      .NLANES(NLANES)
   ) u_readback (
      .clk_x     (clk_x),
      .reset_i   (reset_i),
      .wb_cyc_i  (wb_cyc_i),
      .wb_stb_i  (wb_stb_i),
      .wb_we_i   (wb_we_i),
      .wb_adr_i  (wb_adr_i),
      .wb_dat_o  (wb_dat_o),
      .wb_ack_o  (wb_ack_o),
      .bank_i    (bank_o),
      .rd_bank_o (rd_bank),
      .rd_slot_o (rd_slot),
      .rd_comp_o (rd_comp),
      .rd_dat_i  (rd_dat),
      .rd_valid_i(rd_valid)
   );

endmodule

/* verif/correlator_block_properties.sv */
`timescale 1ns/1ps

module correlator_block_properties
   import corr_types_pkg::*;
#(
   parameter int TRATE = TRATE_DEF
) (
   input logic        clk_x,
   input logic        reset_i,
   input logic        en_i,
   input logic        ready_i,
   input logic        bank_i,
   input logic        cyc_i,
   input logic        stb_i,
   input logic        ack_i,
   input ctrl_state_t state_i      // Controller FSM state
);

   int unsigned fail_cnt = 0;      // Read by the testbench at the end
   int unsigned busy_cnt;          // Cycles left of the current sample
   logic        req;

   assign req = cyc_i && stb_i;

   always_ff @(posedge clk_x) begin
      if (reset_i)
         busy_cnt <= 0;
      else if (en_i && ready_i)
         busy_cnt <= TRATE;        // Sample accepted
      else if (busy_cnt != 0)
         busy_cnt <= busy_cnt - 1;
   end

   // ------------------------------
   // Wishbone handshake
   // ------------------------------
   ack_follows_req: assert property (@(posedge clk_x) disable iff (reset_i)
      (req && !ack_i) |=> ack_i)
   else begin
      fail_cnt++;
      $error("No ack on the cycle after a new request");
   end

   ack_one_cycle: assert property (@(posedge clk_x) disable iff (reset_i)
      ack_i |=> !ack_i)
   else begin
      fail_cnt++;
      $error("Ack held for more than one cycle");
   end

   ack_needs_req: assert property (@(posedge clk_x) disable iff (reset_i)
      ack_i |-> req)
   else begin
      fail_cnt++;
      $error("Ack raised without cyc and stb");
   end

   // ------------------------------
   // Sample and bank timing
   // ------------------------------
   ready_held_low: assert property (@(posedge clk_x) disable iff (reset_i)
      (busy_cnt != 0) |-> !ready_i)
   else begin
      fail_cnt++;
      $error("Ready high while a sample is still in its slots");
   end

   run_length: assert property (@(posedge clk_x) disable iff (reset_i)
      (busy_cnt == 1) |=> (state_i != ST_RUN))
   else begin
      fail_cnt++;
      $error("Controller still running after the last slot");
   end

   bank_in_drain: assert property (@(posedge clk_x) disable iff (reset_i)
      (state_i != ST_DRAIN) |=> $stable(bank_i))
   else begin
      fail_cnt++;
      $error("Bank changed outside the drain state");
   end

endmodule

bind correlator_block correlator_block_properties #(
   .TRATE(TRATE)
) u_props (
   .clk_x  (clk_x),
   .reset_i(reset_i),
   .en_i   (en_i),
   .ready_i(ready_o),
   .bank_i (bank_o),
   .cyc_i  (wb_cyc_i),
   .stb_i  (wb_stb_i),
   .ack_i  (wb_ack_o),
   .state_i(u_control.state_q)
);

/* verif/correlator_block_tb.sv */
`timescale 1ns/1ps

module correlator_block_tb
   import corr_types_pkg::*;
   import corr_bus_pkg::*;
();

   localparam int IBITS  = IBITS_DEF;
   localparam int ACCUM  = ACCUM_DEF;
   localparam int TRATE  = TRATE_DEF;
   localparam int NLANES = NLANES_DEF;
   localparam int NENT   = NLANES * TRATE;      // Entries per bank
   localparam int BURST  = 24;                  // Samples per interval
   localparam int NSAMP  = 2 * BURST + BURST / 2;
   localparam int NPASS  = 5;                   // Full read-back passes
   localparam int MAX_CYCLES = (NSAMP + 8) * (TRATE + 2) + (NPASS * 2 * NENT + 1) * 3 + 100;

   // Entry (lane*TRATE + slot) holds {a, b} with entry 0 in the low bits
   localparam logic [NLANES*TRATE*2*ANT_W-1:0] PAIRS = {
      3'd7, 3'd7,  3'd6, 3'd7,  3'd5, 3'd7,  3'd4, 3'd7,   // Lane 3 with an autocorrelation
      3'd5, 3'd6,  3'd4, 3'd6,  3'd3, 3'd6,  3'd4, 3'd5,   // Lane 2
      3'd3, 3'd5,  3'd3, 3'd4,  3'd2, 3'd7,  3'd2, 3'd6,   // Lane 1
      3'd0, 3'd0,  3'd3, 3'd0,  3'd2, 3'd1,  3'd7, 3'd0    // Lane 0
   };

   logic     clk_x;
   logic     reset_i;
   logic     en_i;
   sample_t  re_i;
   sample_t  im_i;
   logic     sw_i;
   logic     ready_o;
   logic     bank_o;
   logic     wb_cyc_i;
   logic     wb_stb_i;
   logic     wb_we_i;
   wb_adr_t  wb_adr_i;
   wb_data_t wb_dat_o;
   logic     wb_ack_o;

   // Reference model of both visibility banks
   acc_t        ref_re [2][NENT];
   acc_t        ref_im [2][NENT];
   logic        ref_valid [2][NENT];
   logic        ref_bank;                       // Active bank
   logic [31:0] rng;
   int unsigned data_errs;
   int unsigned check_errs;
   int unsigned cycles = 0;

   correlator_block #(
      .IBITS (IBITS),
      .ACCUM (ACCUM),
      .TRATE (TRATE),
      .NLANES(NLANES),
      .PAIRS (PAIRS)
   ) uut (
      .clk_x   (clk_x),
      .reset_i (reset_i),
      .en_i    (en_i),
      .re_i    (re_i),
      .im_i    (im_i),
      .sw_i    (sw_i),
      .ready_o (ready_o),
      .bank_o  (bank_o),
      .wb_cyc_i(wb_cyc_i),
      .wb_stb_i(wb_stb_i),
      .wb_we_i (wb_we_i),
      .wb_adr_i(wb_adr_i),
      .wb_dat_o(wb_dat_o),
      .wb_ack_o(wb_ack_o)
   );

   initial begin
      clk_x = 1'b0;
      forever #2 clk_x = ~clk_x;                // 4 ns period
   end

   // ------------------------------
   // Helpers
   // ------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int sign_val(input logic b);
      return b ? -1 : 1;                        // Sign bit 1 is -1
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         check_errs++;
         $display("ERROR %s: expected %h, got %h", name, exp, got);
      end
   endtask

   // Adds one sample's products into the active model bank
   task automatic model_accumulate(input sample_t re, input sample_t im);
      ant_idx_t a;
      ant_idx_t b;
      int       pr;
      int       pi;
      for (int e = 0; e < NENT; e++) begin
         a  = PAIRS[e*2*ANT_W + ANT_W +: ANT_W];
         b  = PAIRS[e*2*ANT_W +: ANT_W];         // Conjugated antenna
         pr = sign_val(re[a]) * sign_val(re[b]) + sign_val(im[a]) * sign_val(im[b]);
         pi = sign_val(im[a]) * sign_val(re[b]) - sign_val(re[a]) * sign_val(im[b]);
         if (!ref_valid[ref_bank][e]) begin     // First access after a switch
            ref_re[ref_bank][e]    = '0;
            ref_im[ref_bank][e]    = '0;
            ref_valid[ref_bank][e] = 1'b1;
         end
         ref_re[ref_bank][e] = ref_re[ref_bank][e] + acc_t'(pr);  // Wraps
         ref_im[ref_bank][e] = ref_im[ref_bank][e] + acc_t'(pi);
      end
   endtask

   task automatic wait_ready();
      while (!ready_o) begin
         @(posedge clk_x);
         #1;
      end
   endtask

   // ------------------------------
   // Stimulus tasks
   // ------------------------------
   task automatic send_sample(input sample_t re, input sample_t im);
      wait_ready();
      en_i = 1'b1;
      re_i = re;
      im_i = im;
      @(posedge clk_x);                          // Accepted on this edge
      #1;
      en_i = 1'b0;
      model_accumulate(re, im);
   endtask

   // Offer that must be dropped and is skipped by the model
   task automatic offer_while_busy(input sample_t re, input sample_t im);
      check_bit("ready_o", ready_o, 1'b0);
      en_i = 1'b1;
      re_i = re;
      im_i = im;
      @(posedge clk_x);
      #1;
      en_i = 1'b0;
   endtask

   task automatic run_burst(input int count);
      sample_t re;
      sample_t im;
      for (int n = 0; n < count; n++) begin
         rng = xorshift32(rng);
         re  = sample_t'(rng);
         im  = sample_t'(rng >> IBITS);
         send_sample(re, im);
         if (rng[31]) begin
            rng = xorshift32(rng);
            offer_while_busy(sample_t'(rng), sample_t'(rng >> IBITS));
         end
      end
   endtask

   task automatic request_switch();
      sw_i = 1'b1;
      @(posedge clk_x);
      #1;
      sw_i = 1'b0;
      wait_ready();                              // Held low until the swap is done
      ref_bank = !ref_bank;
      for (int e = 0; e < NENT; e++)
         ref_valid[ref_bank][e] = 1'b0;         // New bank starts empty
      check_bit("bank_o", bank_o, ref_bank);
   endtask

   // ------------------------------
   // Wishbone master
   // ------------------------------
   task automatic wb_cycle(input logic we, input wb_adr_t adr, output wb_data_t dat);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      @(posedge clk_x);
      #1;
      while (!wb_ack_o) begin
         @(posedge clk_x);
         #1;
      end
      dat = wb_dat_o;
      @(posedge clk_x);                          // Cycle ends on the ack edge
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   function automatic wb_adr_t entry_adr(input int lane, input int slot, input logic comp);
      wb_adr_t adr;
      adr = '0;
      adr[ADR_COMP_OFS]               = comp;
      adr[ADR_SLOT_OFS +: ADR_SLOT_W] = ADR_SLOT_W'(slot);
      adr[ADR_LANE_OFS +: ADR_LANE_W] = ADR_LANE_W'(lane);
      return adr;
   endfunction

   task automatic check_entry(input int lane, input int slot, input logic comp);
      wb_data_t got;
      wb_data_t exp;
      logic     bk;
      int       e;
      bk  = !ref_bank;                           // Host sees the inactive bank
      e   = lane * TRATE + slot;
      exp = ref_valid[bk][e] ? wb_data_t'(comp ? ref_im[bk][e] : ref_re[bk][e]) : '0;
      wb_cycle(1'b0, entry_adr(lane, slot, comp), got);
      assert (got === exp) else begin
         data_errs++;
         $display("ERROR wb_dat_o lane %0d slot %0d comp %0d: expected %h, got %h",
                  lane, slot, comp, exp, got);
      end
   endtask

   task automatic check_bank();
      for (int l = 0; l < NLANES; l++)
         for (int s = 0; s < TRATE; s++)
            for (int c = 0; c < 2; c++)
               check_entry(l, s, c[0]);
   endtask

   // ------------------------------
   // Timeout
   // ------------------------------
   always @(posedge clk_x) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Errors: data %0d, control %0d, assertions %0d",
                  data_errs, check_errs, uut.u_props.fail_cnt);
         $display("TEST FAILED");
         $finish;
      end
   end

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      wb_data_t    wdat;
      int unsigned total;
      reset_i  = 1'b1;
      en_i     = 1'b0;
      re_i     = '0;
      im_i     = '0;
      sw_i     = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_adr_i = '0;
      rng        = 32'h808e9112;
      ref_bank   = 1'b0;
      data_errs  = 0;
      check_errs = 0;
      for (int e = 0; e < NENT; e++) begin
         ref_valid[0][e] = 1'b0;
         ref_valid[1][e] = 1'b0;
      end
      repeat (5) @(posedge clk_x);
      #1;
      reset_i = 1'b0;

      check_bit("ready_o", ready_o, 1'b1);       // State after reset
      check_bit("bank_o", bank_o, 1'b0);
      check_bit("wb_ack_o", wb_ack_o, 1'b0);
      check_bank();                              // Inactive bank empty

      run_burst(BURST);                          // Interval into bank 0
      request_switch();
      check_bank();

      run_burst(BURST);                          // Interval into bank 1
      request_switch();
      check_bank();

      run_burst(BURST / 2);                      // Bank 0 reused without its old sums
      wait_ready();
      request_switch();                          // Switch from idle
      check_bank();

      wb_cycle(1'b1, entry_adr(1, 2, 1'b0), wdat);  // Write is ignored
      assert (wdat === '0) else begin
         data_errs++;
         $display("ERROR wb_dat_o on write: expected %h, got %h", wb_data_t'(0), wdat);
      end
      check_bank();

      @(posedge clk_x);
      #1;
      total = data_errs + check_errs + uut.u_props.fail_cnt;
      $display("Errors: data %0d, control %0d, assertions %0d",
               data_errs, check_errs, uut.u_props.fail_cnt);
      if (total == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
